// ==== compile.f ====
source/ddr2_cpu_pkg.sv
source/mem_req_if.sv
source/reg_wb_attach.sv
source/mem_wb_bridge.sv
source/ddr_cmd_issuer.sv
source/ddr2_cpu_interface.sv
tb/ddr2_ctrl_model.sv
tb/tb_ddr2_cpu_interface.sv

// ==== source/ddr2_cpu_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr2_cpu_interface #(
  parameter int SOFT_ADDR_BITS = 8
) (
  input  wire                          ddr_clk_0,
  input  wire                          ddr_reset_int,
  input  wire                          reg_wb_cyc_i,
  input  wire                          reg_wb_stb_i,
  input  wire                          reg_wb_we_i,
  input  wire ddr2_cpu_pkg::wb_sel_t   reg_wb_sel_i,
  input  wire [31:0]                   reg_wb_adr_i,
  input  wire ddr2_cpu_pkg::wb_data_t  reg_wb_dat_i,
  output wire ddr2_cpu_pkg::wb_data_t  reg_wb_dat_o,
  output wire                          reg_wb_ack_o,
  input  wire                          mem_wb_cyc_i,
  input  wire                          mem_wb_stb_i,
  input  wire                          mem_wb_we_i,
  input  wire ddr2_cpu_pkg::wb_sel_t   mem_wb_sel_i,
  input  wire [31:0]                   mem_wb_adr_i,
  input  wire ddr2_cpu_pkg::wb_data_t  mem_wb_dat_i,
  output wire ddr2_cpu_pkg::wb_data_t  mem_wb_dat_o,
  output wire                          mem_wb_ack_o,
  input  wire                          ddr2_phy_rdy_i,
  output wire                          ddr2_request_o,
  input  wire                          ddr2_granted_i,
  output wire                          ddr2_rst_o,
  output wire ddr2_cpu_pkg::ddr_cmd_e  ddr2_af_cmnd_o,
  output wire ddr2_cpu_pkg::ddr_addr_t ddr2_af_addr_o,
  output wire                          ddr2_af_wen_o,
  input  wire                          ddr2_af_afull_i,
  output wire ddr2_cpu_pkg::ddr_word_t ddr2_df_data_o,
  output wire ddr2_cpu_pkg::ddr_mask_t ddr2_df_mask_o,
  output wire                          ddr2_df_wen_o,
  input  wire                          ddr2_df_afull_i,
  input  wire ddr2_cpu_pkg::ddr_word_t ddr2_data_i,
  input  wire                          ddr2_dvalid_i
);

  wire [SOFT_ADDR_BITS-1:0] soft_addr;

  mem_req_if mem_req ();

  reg_wb_attach #(
    .SOFT_ADDR_BITS (SOFT_ADDR_BITS)
  ) reg_wb_attach_i (
    .ddr_clk_0     (ddr_clk_0),
    .ddr_reset_int (ddr_reset_int),
    .wb_cyc_i      (reg_wb_cyc_i),
    .wb_stb_i      (reg_wb_stb_i),
    .wb_we_i       (reg_wb_we_i),
    .wb_sel_i      (reg_wb_sel_i),
    .wb_adr_i      (reg_wb_adr_i),
    .wb_dat_i      (reg_wb_dat_i),
    .wb_dat_o      (reg_wb_dat_o),
    .wb_ack_o      (reg_wb_ack_o),
    .phy_rdy_i     (ddr2_phy_rdy_i),
    .bus_granted_i (ddr2_granted_i),
    .bus_request_o (ddr2_request_o),
    .soft_addr_o   (soft_addr),
    .ddr_rst_o     (ddr2_rst_o)
  );

  mem_wb_bridge #(
    .SOFT_ADDR_BITS (SOFT_ADDR_BITS)
  ) mem_wb_bridge_i (
    .ddr_clk_0     (ddr_clk_0),
    .ddr_reset_int (ddr_reset_int),
    .ddr_rst_i     (ddr2_rst_o),
    .wb_cyc_i      (mem_wb_cyc_i),
    .wb_stb_i      (mem_wb_stb_i),
    .wb_we_i       (mem_wb_we_i),
    .wb_sel_i      (mem_wb_sel_i),
    .wb_adr_i      (mem_wb_adr_i),
    .wb_dat_i      (mem_wb_dat_i),
    .wb_dat_o      (mem_wb_dat_o),
    .wb_ack_o      (mem_wb_ack_o),
    .soft_addr_i   (soft_addr),
    .req           (mem_req)
  );

  ddr_cmd_issuer ddr_cmd_issuer_i (
    .ddr_clk_0     (ddr_clk_0),
    .ddr_reset_int (ddr_reset_int),
    .ddr_rst_i     (ddr2_rst_o),
    .req           (mem_req),
    .granted_i     (ddr2_granted_i),
    .af_cmnd_o     (ddr2_af_cmnd_o),
    .af_addr_o     (ddr2_af_addr_o),
    .af_wen_o      (ddr2_af_wen_o),
    .af_afull_i    (ddr2_af_afull_i),
    .df_data_o     (ddr2_df_data_o),
    .df_mask_o     (ddr2_df_mask_o),
    .df_wen_o      (ddr2_df_wen_o),
    .df_afull_i    (ddr2_df_afull_i),
    .rd_data_i     (ddr2_data_i),
    .rd_dvalid_i   (ddr2_dvalid_i)
  );

endmodule

`default_nettype wire

// ==== source/ddr2_cpu_pkg.sv ====
`default_nettype none

package ddr2_cpu_pkg;

  // command codes understood by the DDR2 controller address FIFO
  typedef enum logic [2:0] {
    DDR_CMD_WRITE = 3'b000,
    DDR_CMD_READ  = 3'b001
  } ddr_cmd_e;

  // controller command address, one unit per 16-bit halfword
  typedef logic [30:0] ddr_addr_t;

  // one data FIFO or read data word
  typedef logic [127:0] ddr_word_t;

  // a set bit keeps the matching byte from being written
  typedef logic [15:0] ddr_mask_t;

  typedef logic [15:0] wb_data_t;
  typedef logic [1:0]  wb_sel_t;

  // register offsets, decoded from wishbone address bits [2:1]
  localparam logic [1:0] REG_STATUS  = 2'd0;
  localparam logic [1:0] REG_PAGE    = 2'd1;
  localparam logic [1:0] REG_REQUEST = 2'd2;

  // cycles the DDR reset is held high after a trigger
  localparam int RESET_STRETCH = 8;

endpackage

`default_nettype wire

// ==== source/ddr_cmd_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_cmd_issuer (
  input  wire                          ddr_clk_0,
  input  wire                          ddr_reset_int,
  input  wire                          ddr_rst_i,
  mem_req_if.issuer                    req,
  input  wire                          granted_i,
  output ddr2_cpu_pkg::ddr_cmd_e       af_cmnd_o,
  output ddr2_cpu_pkg::ddr_addr_t      af_addr_o,
  output logic                         af_wen_o,
  input  wire                          af_afull_i,
  output ddr2_cpu_pkg::ddr_word_t      df_data_o,
  output ddr2_cpu_pkg::ddr_mask_t      df_mask_o,
  output logic                         df_wen_o,
  input  wire                          df_afull_i,
  input  wire ddr2_cpu_pkg::ddr_word_t rd_data_i,
  input  wire                          rd_dvalid_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_WR2, ST_RD_WAIT, ST_RESP} state_e;

  state_e                  state;
  logic                    accept;
  logic                    rd_dvalid_q;
  ddr2_cpu_pkg::ddr_word_t rd_data_q;

  // both FIFOs need room since a write takes one command and two data slots
  assign req.req_ready = (state == ST_IDLE) && granted_i && !af_afull_i &&
                         !df_afull_i && !ddr_rst_i;
  assign accept = req.req_valid && req.req_ready;

  always_ff @(posedge ddr_clk_0) begin
    if (ddr_reset_int || ddr_rst_i) begin
      state          <= ST_IDLE;
      af_wen_o       <= 1'b0;
      df_wen_o       <= 1'b0;
      req.resp_valid <= 1'b0;
      rd_dvalid_q    <= 1'b0;
    end else begin
      af_wen_o       <= 1'b0;
      df_wen_o       <= 1'b0;
      req.resp_valid <= 1'b0;
      rd_dvalid_q    <= rd_dvalid_i;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            af_wen_o <= 1'b1;
            if (req.req_we) begin
              df_wen_o <= 1'b1;
              state    <= ST_WR2;
            end else begin
              state <= ST_RD_WAIT;
            end
          end
        end
        ST_WR2: begin
          // second burst beat waits for data FIFO room
          if (!df_afull_i) begin
            df_wen_o <= 1'b1;
            state    <= ST_RESP;
          end
        end
        ST_RD_WAIT: begin
          if (rd_dvalid_q) begin
            req.resp_valid <= 1'b1;
            state          <= ST_IDLE;
          end
        end
        ST_RESP: begin
          req.resp_valid <= 1'b1;
          state          <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge ddr_clk_0) begin
    rd_data_q <= rd_data_i;
    if (accept) begin
      if (req.req_we) begin
        af_cmnd_o <= ddr2_cpu_pkg::DDR_CMD_WRITE;
      end else begin
        af_cmnd_o <= ddr2_cpu_pkg::DDR_CMD_READ;
      end
      af_addr_o <= req.req_addr;
      df_data_o <= req.req_data;
      df_mask_o <= req.req_mask;
    end else if ((state == ST_WR2) && !df_afull_i) begin
      // the second beat writes nothing
      df_data_o <= '0;
      df_mask_o <= '1;
    end
    if ((state == ST_RD_WAIT) && rd_dvalid_q) begin
      req.resp_data <= rd_data_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one memory request from the wishbone side and its single response
interface mem_req_if;

  logic                    req_valid;
  logic                    req_ready;
  logic                    req_we;
  ddr2_cpu_pkg::ddr_addr_t req_addr;
  ddr2_cpu_pkg::ddr_word_t req_data;
  ddr2_cpu_pkg::ddr_mask_t req_mask;

  // resp_data only carries meaning for reads
  logic                    resp_valid;
  ddr2_cpu_pkg::ddr_word_t resp_data;

  modport bridge (
    output req_valid, req_we, req_addr, req_data, req_mask,
    input  req_ready, resp_valid, resp_data
  );

  modport issuer (
    input  req_valid, req_we, req_addr, req_data, req_mask,
    output req_ready, resp_valid, resp_data
  );

endinterface

`default_nettype wire

// ==== source/mem_wb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_bridge #(
  parameter int SOFT_ADDR_BITS = 8
) (
  input  wire                         ddr_clk_0,
  input  wire                         ddr_reset_int,
  input  wire                         ddr_rst_i,
  input  wire                         wb_cyc_i,
  input  wire                         wb_stb_i,
  input  wire                         wb_we_i,
  input  wire ddr2_cpu_pkg::wb_sel_t  wb_sel_i,
  input  wire [31:0]                  wb_adr_i,
  input  wire ddr2_cpu_pkg::wb_data_t wb_dat_i,
  output ddr2_cpu_pkg::wb_data_t      wb_dat_o,
  output logic                        wb_ack_o,
  input  wire [SOFT_ADDR_BITS-1:0]    soft_addr_i,
  mem_req_if.bridge                   req
);

  // halfword address bits that sit between the page and the lane number
  localparam int LINE_BITS = 28 - SOFT_ADDR_BITS;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_e;

  state_e     state;
  logic [2:0] lane;
  logic [2:0] lane_q;
  logic       start;

  assign lane  = wb_adr_i[3:1];
  assign start = (state == ST_IDLE) && wb_cyc_i && wb_stb_i && !wb_ack_o;

  always_ff @(posedge ddr_clk_0) begin
    if (ddr_reset_int || ddr_rst_i) begin
      state         <= ST_IDLE;
      req.req_valid <= 1'b0;
      wb_ack_o      <= 1'b0;
    end else begin
      wb_ack_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            req.req_valid <= 1'b1;
            state         <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (req.req_ready) begin
            req.req_valid <= 1'b0;
            state         <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (req.resp_valid) begin
            wb_ack_o <= 1'b1;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request fields are frozen at the start of the access and held until accepted
  always_ff @(posedge ddr_clk_0) begin
    if (start) begin
      req.req_we   <= wb_we_i;
      req.req_addr <= {soft_addr_i, wb_adr_i[LINE_BITS+3:4], 3'b000};
      req.req_data <= ddr2_cpu_pkg::ddr_word_t'(wb_dat_i) << {lane, 4'b0000};
      // only the selected bytes of the addressed lane are written
      req.req_mask <= ~(ddr2_cpu_pkg::ddr_mask_t'(wb_sel_i) << {lane, 1'b0});
      lane_q       <= lane;
    end
    if ((state == ST_WAIT) && req.resp_valid && !req.req_we) begin
      wb_dat_o <= req.resp_data[{lane_q, 4'b0000} +: 16];
    end
  end

endmodule

`default_nettype wire

// ==== source/reg_wb_attach.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_wb_attach #(
  parameter int SOFT_ADDR_BITS = 8
) (
  input  wire                       ddr_clk_0,
  input  wire                       ddr_reset_int,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire ddr2_cpu_pkg::wb_sel_t  wb_sel_i,
  input  wire [31:0]                wb_adr_i,
  input  wire ddr2_cpu_pkg::wb_data_t wb_dat_i,
  output ddr2_cpu_pkg::wb_data_t    wb_dat_o,
  output logic                      wb_ack_o,
  input  wire                       phy_rdy_i,
  input  wire                       bus_granted_i,
  output logic                      bus_request_o,
  output logic [SOFT_ADDR_BITS-1:0] soft_addr_o,
  output logic                      ddr_rst_o
);

  logic [1:0]  reg_sel;
  logic        wb_access;
  logic        wr_en;
  logic        soft_reset;
  logic [15:0] page_wide;
  logic [15:0] page_merge;
  logic [ddr2_cpu_pkg::RESET_STRETCH-1:0] rst_shift;

  assign reg_sel   = wb_adr_i[2:1];
  // the ack register blocks a second access while the strobe is still held
  assign wb_access = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en     = wb_access && wb_we_i;

  assign page_wide  = 16'(soft_addr_o);
  // byte lanes not selected keep their current page bits
  assign page_merge = {wb_sel_i[1] ? wb_dat_i[15:8] : page_wide[15:8],
                       wb_sel_i[0] ? wb_dat_i[7:0]  : page_wide[7:0]};

  assign soft_reset = wr_en && (reg_sel == ddr2_cpu_pkg::REG_STATUS) &&
                      wb_sel_i[0] && wb_dat_i[0];

  always_ff @(posedge ddr_clk_0) begin
    if (ddr_reset_int) begin
      wb_ack_o      <= 1'b0;
      bus_request_o <= 1'b0;
      soft_addr_o   <= '0;
    end else begin
      wb_ack_o <= wb_access;
      if (wr_en && (reg_sel == ddr2_cpu_pkg::REG_PAGE)) begin
        soft_addr_o <= page_merge[SOFT_ADDR_BITS-1:0];
      end
      if (wr_en && (reg_sel == ddr2_cpu_pkg::REG_REQUEST) && wb_sel_i[0]) begin
        bus_request_o <= wb_dat_i[0];
      end
    end
  end

  // read data is sampled in the same cycle the ack is raised
  always_ff @(posedge ddr_clk_0) begin
    if (wb_access) begin
      case (reg_sel)
        ddr2_cpu_pkg::REG_STATUS:  wb_dat_o <= {14'd0, bus_granted_i, phy_rdy_i};
        ddr2_cpu_pkg::REG_PAGE:    wb_dat_o <= page_wide;
        ddr2_cpu_pkg::REG_REQUEST: wb_dat_o <= {15'd0, bus_request_o};
        default:                   wb_dat_o <= '0;
      endcase
    end
  end

  // reset stretcher, the top bit stays high for RESET_STRETCH cycles after a load
  always_ff @(posedge ddr_clk_0) begin
    if (ddr_reset_int || soft_reset) begin
      rst_shift <= '1;
    end else begin
      rst_shift <= {rst_shift[ddr2_cpu_pkg::RESET_STRETCH-2:0], 1'b0};
    end
  end

  assign ddr_rst_o = rst_shift[ddr2_cpu_pkg::RESET_STRETCH-1];

endmodule

`default_nettype wire

// ==== tb/ddr2_ctrl_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// behavioral DDR2 controller, everything it drives changes on the falling edge
module ddr2_ctrl_model (
  input  wire                          ddr_clk_0,
  input  wire                          rst_i,
  input  wire                          rand_full_i,
  input  wire                          hold_full_i,
  input  wire ddr2_cpu_pkg::ddr_cmd_e  af_cmnd_i,
  input  wire ddr2_cpu_pkg::ddr_addr_t af_addr_i,
  input  wire                          af_wen_i,
  output logic                         af_afull_o,
  input  wire ddr2_cpu_pkg::ddr_word_t df_data_i,
  input  wire ddr2_cpu_pkg::ddr_mask_t df_mask_i,
  input  wire                          df_wen_i,
  output logic                         df_afull_o,
  output ddr2_cpu_pkg::ddr_word_t      data_o,
  output logic                         dvalid_o
);

  ddr2_cpu_pkg::ddr_word_t mem [ddr2_cpu_pkg::ddr_addr_t];
  ddr2_cpu_pkg::ddr_addr_t wr_addr;
  ddr2_cpu_pkg::ddr_addr_t rd_addr;
  int wr_beat;
  int rd_wait;
  int rd_beat;

  // words never written return a pattern built from their address
  function automatic ddr2_cpu_pkg::ddr_word_t fetch(input ddr2_cpu_pkg::ddr_addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {4{1'b0, addr}};
  endfunction

  task automatic store(input ddr2_cpu_pkg::ddr_addr_t addr,
                       input ddr2_cpu_pkg::ddr_word_t data,
                       input ddr2_cpu_pkg::ddr_mask_t mask);
    ddr2_cpu_pkg::ddr_word_t word;
    word = fetch(addr);
    for (int b = 0; b < 16; b++) begin
      if (!mask[b]) begin
        word[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    mem[addr] = word;
  endtask

  initial begin
    af_afull_o = 1'b0;
    df_afull_o = 1'b0;
    data_o     = '0;
    dvalid_o   = 1'b0;
    wr_addr    = '0;
    rd_addr    = '0;
    wr_beat    = 0;
    rd_wait    = 0;
    rd_beat    = 0;
  end

  always @(negedge ddr_clk_0) begin
    dvalid_o = 1'b0;
    if (rst_i === 1'b1) begin
      wr_beat = 0;
      rd_wait = 0;
      rd_beat = 0;
    end else begin
      if (af_wen_i === 1'b1) begin
        if (af_cmnd_i == ddr2_cpu_pkg::DDR_CMD_WRITE) begin
          wr_addr = af_addr_i;
          wr_beat = 0;
        end else begin
          rd_addr = af_addr_i;
          rd_wait = 2 + ($urandom % 4);
          rd_beat = 0;
        end
      end
      // each burst beat covers eight halfwords
      if (df_wen_i === 1'b1) begin
        store(wr_addr + 31'(8 * wr_beat), df_data_i, df_mask_i);
        wr_beat++;
      end
      if (rd_beat > 0) begin
        data_o   = fetch(rd_addr + 31'd8);
        dvalid_o = 1'b1;
        rd_beat  = 0;
      end else if (rd_wait > 0) begin
        rd_wait--;
        if (rd_wait == 0) begin
          data_o   = fetch(rd_addr);
          dvalid_o = 1'b1;
          rd_beat  = 1;
        end
      end
    end
    af_afull_o = hold_full_i || (rand_full_i && ($urandom % 4 == 0));
    df_afull_o = hold_full_i || (rand_full_i && ($urandom % 4 == 0));
  end

endmodule

`default_nettype wire

// ==== tb/tb_ddr2_cpu_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ddr2_cpu_interface;

  localparam int SOFT_ADDR_BITS = 8;
  localparam int TIMEOUT = 200;
  localparam logic [31:0] LANE_BASE = 32'h0000_3450;

  logic                    ddr_clk_0;
  logic                    ddr_reset_int;
  logic                    reg_wb_cyc_i;
  logic                    reg_wb_stb_i;
  logic                    reg_wb_we_i;
  ddr2_cpu_pkg::wb_sel_t   reg_wb_sel_i;
  logic [31:0]             reg_wb_adr_i;
  ddr2_cpu_pkg::wb_data_t  reg_wb_dat_i;
  ddr2_cpu_pkg::wb_data_t  reg_wb_dat_o;
  logic                    reg_wb_ack_o;
  logic                    mem_wb_cyc_i;
  logic                    mem_wb_stb_i;
  logic                    mem_wb_we_i;
  ddr2_cpu_pkg::wb_sel_t   mem_wb_sel_i;
  logic [31:0]             mem_wb_adr_i;
  ddr2_cpu_pkg::wb_data_t  mem_wb_dat_i;
  ddr2_cpu_pkg::wb_data_t  mem_wb_dat_o;
  logic                    mem_wb_ack_o;
  logic                    ddr2_phy_rdy_i;
  logic                    ddr2_request_o;
  logic                    ddr2_granted_i;
  logic                    ddr2_rst_o;
  ddr2_cpu_pkg::ddr_cmd_e  ddr2_af_cmnd_o;
  ddr2_cpu_pkg::ddr_addr_t ddr2_af_addr_o;
  logic                    ddr2_af_wen_o;
  logic                    ddr2_af_afull_i;
  ddr2_cpu_pkg::ddr_word_t ddr2_df_data_o;
  ddr2_cpu_pkg::ddr_mask_t ddr2_df_mask_o;
  logic                    ddr2_df_wen_o;
  logic                    ddr2_df_afull_i;
  ddr2_cpu_pkg::ddr_word_t ddr2_data_i;
  logic                    ddr2_dvalid_i;
  logic                    rand_full;
  logic                    hold_full;

  // FIFO writes seen on the controller side
  ddr2_cpu_pkg::ddr_cmd_e  cmd_q [$];
  ddr2_cpu_pkg::ddr_addr_t addr_q [$];
  ddr2_cpu_pkg::ddr_word_t data_q [$];
  ddr2_cpu_pkg::ddr_mask_t mask_q [$];

  string cur_test;
  int    errors = 0;
  int    passed = 0;
  int    failed = 0;

  ddr2_cpu_interface #(
    .SOFT_ADDR_BITS (SOFT_ADDR_BITS)
  ) dut_i (.*);

  ddr2_ctrl_model ctrl_model_i (
    .ddr_clk_0   (ddr_clk_0),
    .rst_i       (ddr2_rst_o),
    .rand_full_i (rand_full),
    .hold_full_i (hold_full),
    .af_cmnd_i   (ddr2_af_cmnd_o),
    .af_addr_i   (ddr2_af_addr_o),
    .af_wen_i    (ddr2_af_wen_o),
    .af_afull_o  (ddr2_af_afull_i),
    .df_data_i   (ddr2_df_data_o),
    .df_mask_i   (ddr2_df_mask_o),
    .df_wen_i    (ddr2_df_wen_o),
    .df_afull_o  (ddr2_df_afull_i),
    .data_o      (ddr2_data_i),
    .dvalid_o    (ddr2_dvalid_i)
  );

  initial ddr_clk_0 = 1'b0;
  always #50 ddr_clk_0 = ~ddr_clk_0;

  always @(negedge ddr_clk_0) begin
    if (ddr2_af_wen_o === 1'b1) begin
      cmd_q.push_back(ddr2_af_cmnd_o);
      addr_q.push_back(ddr2_af_addr_o);
    end
    if (ddr2_df_wen_o === 1'b1) begin
      data_q.push_back(ddr2_df_data_o);
      mask_q.push_back(ddr2_df_mask_o);
    end
  end

  task automatic compare_wb_data(input string what, input ddr2_cpu_pkg::wb_data_t exp,
                                 input ddr2_cpu_pkg::wb_data_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_ddr_addr(input string what, input ddr2_cpu_pkg::ddr_addr_t exp,
                                  input ddr2_cpu_pkg::ddr_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_ddr_mask(input string what, input ddr2_cpu_pkg::ddr_mask_t exp,
                                  input ddr2_cpu_pkg::ddr_mask_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_ddr_cmd(input string what, input ddr2_cpu_pkg::ddr_cmd_e exp,
                                 input ddr2_cpu_pkg::ddr_cmd_e act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic compare_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input int errs_at_start);
    if (errors == errs_at_start) begin
      $display("%s: passed", cur_test);
      passed++;
    end else begin
      $display("%s: failed with %0d errors", cur_test, errors - errs_at_start);
      failed++;
    end
  endtask

  // page in the top bits above the halfword address with its lane bits cleared
  function automatic ddr2_cpu_pkg::ddr_addr_t expected_cmd_addr(
      input logic [SOFT_ADDR_BITS-1:0] page, input logic [31:0] adr);
    logic [31:0] hw_addr;
    hw_addr = (adr >> 1) & ~32'h7;
    return {page, hw_addr[30-SOFT_ADDR_BITS:0]};
  endfunction

  function automatic ddr2_cpu_pkg::ddr_mask_t expected_mask(input logic [2:0] lane,
                                                            input ddr2_cpu_pkg::wb_sel_t sel);
    ddr2_cpu_pkg::ddr_mask_t mask;
    mask = '1;
    for (int b = 0; b < 2; b++) begin
      if (sel[b]) begin
        mask[lane*2 + b] = 1'b0;
      end
    end
    return mask;
  endfunction

  function automatic ddr2_cpu_pkg::wb_data_t lane_value(input logic [7:0] page, input int lane);
    return {page, 4'(lane), 4'h9};
  endfunction

  // every access task is entered on a falling edge and returns on one
  task automatic reg_access(input logic we, input logic [1:0] offs,
                            input ddr2_cpu_pkg::wb_data_t wdat,
                            output ddr2_cpu_pkg::wb_data_t rdat);
    int waited;
    @(negedge ddr_clk_0);
    reg_wb_cyc_i = 1'b1;
    reg_wb_stb_i = 1'b1;
    reg_wb_we_i  = we;
    reg_wb_sel_i = 2'b11;
    reg_wb_adr_i = {29'd0, offs, 1'b0};
    reg_wb_dat_i = wdat;
    @(negedge ddr_clk_0);
    waited = 1;
    while (!reg_wb_ack_o && waited < TIMEOUT) begin
      @(negedge ddr_clk_0);
      waited++;
    end
    if (!reg_wb_ack_o) begin
      $display("%s: register access at offset %0d got no ack", cur_test, offs);
      errors++;
    end else if (waited != 1) begin
      $display("%s: register ack came after %0d cycles instead of one", cur_test, waited);
      errors++;
    end
    rdat = reg_wb_dat_o;
    reg_wb_cyc_i = 1'b0;
    reg_wb_stb_i = 1'b0;
    reg_wb_we_i  = 1'b0;
  endtask

  task automatic mem_start(input logic we, input logic [31:0] adr,
                           input ddr2_cpu_pkg::wb_data_t wdat,
                           input ddr2_cpu_pkg::wb_sel_t sel);
    @(negedge ddr_clk_0);
    mem_wb_cyc_i = 1'b1;
    mem_wb_stb_i = 1'b1;
    mem_wb_we_i  = we;
    mem_wb_sel_i = sel;
    mem_wb_adr_i = adr;
    mem_wb_dat_i = wdat;
  endtask

  task automatic mem_finish(output ddr2_cpu_pkg::wb_data_t rdat);
    int waited;
    @(negedge ddr_clk_0);
    waited = 1;
    while (!mem_wb_ack_o && waited < TIMEOUT) begin
      @(negedge ddr_clk_0);
      waited++;
    end
    if (!mem_wb_ack_o) begin
      $display("%s: memory access at %h got no ack within %0d cycles",
               cur_test, mem_wb_adr_i, TIMEOUT);
      errors++;
    end
    rdat = mem_wb_dat_o;
    mem_wb_cyc_i = 1'b0;
    mem_wb_stb_i = 1'b0;
    mem_wb_we_i  = 1'b0;
  endtask

  task automatic mem_access(input logic we, input logic [31:0] adr,
                            input ddr2_cpu_pkg::wb_data_t wdat,
                            input ddr2_cpu_pkg::wb_sel_t sel,
                            output ddr2_cpu_pkg::wb_data_t rdat);
    mem_start(we, adr, wdat, sel);
    mem_finish(rdat);
  endtask

  task automatic measure_reset_high(output int cycles);
    cycles = 0;
    while (ddr2_rst_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge ddr_clk_0);
    end
    if (ddr2_rst_o !== 1'b0) begin
      $display("%s: DDR reset output did not go low within %0d cycles", cur_test, TIMEOUT);
    end
  endtask

  task automatic check_stalled(input int cycles);
    logic moved;
    moved = 1'b0;
    repeat (cycles) begin
      @(negedge ddr_clk_0);
      if (mem_wb_ack_o || ddr2_af_wen_o || ddr2_df_wen_o) begin
        moved = 1'b1;
      end
    end
    if (moved) begin
      $display("%s: access went ahead while the controller could not take it", cur_test);
      errors++;
    end
  endtask

  task automatic check_write_burst(input logic [7:0] page, input logic [31:0] adr,
                                   input ddr2_cpu_pkg::wb_data_t wdat,
                                   input ddr2_cpu_pkg::wb_sel_t sel);
    ddr2_cpu_pkg::wb_data_t rd;
    logic [2:0]             lane;
    lane = adr[3:1];
    cmd_q.delete();
    addr_q.delete();
    data_q.delete();
    mask_q.delete();
    mem_access(1'b1, adr, wdat, sel, rd);
    compare_count("command FIFO writes", 1, cmd_q.size());
    compare_count("data FIFO writes", 2, data_q.size());
    if (cmd_q.size() == 1 && data_q.size() == 2) begin
      compare_ddr_cmd("command", ddr2_cpu_pkg::DDR_CMD_WRITE, cmd_q[0]);
      compare_ddr_addr("command address", expected_cmd_addr(page, adr), addr_q[0]);
      compare_wb_data("lane data", wdat, data_q[0][lane*16 +: 16]);
      compare_ddr_mask("first beat mask", expected_mask(lane, sel), mask_q[0]);
      compare_ddr_mask("second beat mask", '1, mask_q[1]);
    end
  endtask

  task automatic read_lanes(input logic [7:0] page);
    ddr2_cpu_pkg::wb_data_t rd;
    for (int i = 0; i < 8; i++) begin
      mem_access(1'b0, LANE_BASE + 32'(2 * i), 16'h0000, 2'b11, rd);
      compare_wb_data("read back", lane_value(page, i), rd);
    end
  endtask

  task automatic test_reset();
    int errs;
    int cycles;
    ddr2_cpu_pkg::wb_data_t rd;
    cur_test = "reset";
    errs = errors;
    if ({reg_wb_ack_o, mem_wb_ack_o, ddr2_af_wen_o, ddr2_df_wen_o,
         ddr2_request_o} !== 5'b00000) begin
      $display("%s: a control output is not low right after reset", cur_test);
      errors++;
    end
    measure_reset_high(cycles);
    compare_count("reset stretch", ddr2_cpu_pkg::RESET_STRETCH, cycles);
    reg_access(1'b1, ddr2_cpu_pkg::REG_STATUS, 16'h0001, rd);
    measure_reset_high(cycles);
    compare_count("soft reset stretch", ddr2_cpu_pkg::RESET_STRETCH, cycles);
    report_test(errs);
  endtask

  task automatic test_registers();
    int errs;
    ddr2_cpu_pkg::wb_data_t rd;
    cur_test = "registers";
    errs = errors;
    ddr2_phy_rdy_i = 1'b1;
    ddr2_granted_i = 1'b0;
    reg_access(1'b0, ddr2_cpu_pkg::REG_STATUS, 16'h0000, rd);
    compare_wb_data("status", 16'h0001, rd);
    ddr2_phy_rdy_i = 1'b0;
    ddr2_granted_i = 1'b1;
    reg_access(1'b0, ddr2_cpu_pkg::REG_STATUS, 16'h0000, rd);
    compare_wb_data("status", 16'h0002, rd);
    reg_access(1'b1, ddr2_cpu_pkg::REG_PAGE, 16'h005A, rd);
    reg_access(1'b0, ddr2_cpu_pkg::REG_PAGE, 16'h0000, rd);
    compare_wb_data("page", 16'h005A, rd);
    reg_access(1'b1, ddr2_cpu_pkg::REG_REQUEST, 16'h0001, rd);
    compare_wb_data("bus request output", 16'h0001, {15'd0, ddr2_request_o});
    reg_access(1'b0, ddr2_cpu_pkg::REG_REQUEST, 16'h0000, rd);
    compare_wb_data("bus request", 16'h0001, rd);
    ddr2_phy_rdy_i = 1'b1;
    report_test(errs);
  endtask

  task automatic test_mem_write();
    int errs;
    ddr2_cpu_pkg::wb_data_t rd;
    cur_test = "mem_write";
    errs = errors;
    rand_full = 1'b1;
    reg_access(1'b1, ddr2_cpu_pkg::REG_PAGE, 16'h003C, rd);
    check_write_burst(8'h3C, 32'h0000_1236, 16'hBEEF, 2'b11);
    check_write_burst(8'h3C, 32'h0004_5678, 16'h55AA, 2'b01);
    check_write_burst(8'h3C, 32'h00AB_CDEA, 16'h1234, 2'b10);
    report_test(errs);
  endtask

  task automatic test_lane_readback();
    int errs;
    logic [7:0] page;
    ddr2_cpu_pkg::wb_data_t rd;
    cur_test = "lane_readback";
    errs = errors;
    rand_full = 1'b1;
    for (int p = 0; p < 2; p++) begin
      page = (p == 0) ? 8'h12 : 8'hA7;
      reg_access(1'b1, ddr2_cpu_pkg::REG_PAGE, {8'h00, page}, rd);
      for (int i = 0; i < 8; i++) begin
        mem_access(1'b1, LANE_BASE + 32'(2 * i), lane_value(page, i), 2'b11, rd);
      end
      read_lanes(page);
    end
    // the first page must still hold its own values
    reg_access(1'b1, ddr2_cpu_pkg::REG_PAGE, 16'h0012, rd);
    read_lanes(8'h12);
    report_test(errs);
  endtask

  task automatic test_back_pressure();
    int errs;
    ddr2_cpu_pkg::wb_data_t rd;
    cur_test = "back_pressure";
    errs = errors;
    rand_full = 1'b0;
    ddr2_granted_i = 1'b0;
    mem_start(1'b1, LANE_BASE + 32'd10, 16'hC0DE, 2'b11);
    check_stalled(10);
    ddr2_granted_i = 1'b1;
    mem_finish(rd);
    hold_full = 1'b1;
    mem_start(1'b0, LANE_BASE + 32'd10, 16'h0000, 2'b11);
    check_stalled(10);
    hold_full = 1'b0;
    mem_finish(rd);
    compare_wb_data("read after stall", 16'hC0DE, rd);
    report_test(errs);
  endtask

  initial begin
    void'($urandom(95589));
    ddr_reset_int  = 1'b1;
    reg_wb_cyc_i   = 1'b0;
    reg_wb_stb_i   = 1'b0;
    reg_wb_we_i    = 1'b0;
    reg_wb_sel_i   = '0;
    reg_wb_adr_i   = '0;
    reg_wb_dat_i   = '0;
    mem_wb_cyc_i   = 1'b0;
    mem_wb_stb_i   = 1'b0;
    mem_wb_we_i    = 1'b0;
    mem_wb_sel_i   = '0;
    mem_wb_adr_i   = '0;
    mem_wb_dat_i   = '0;
    ddr2_phy_rdy_i = 1'b1;
    ddr2_granted_i = 1'b1;
    rand_full      = 1'b0;
    hold_full      = 1'b0;
    repeat (4) @(negedge ddr_clk_0);
    ddr_reset_int = 1'b0;
    test_reset();
    test_registers();
    test_mem_write();
    test_lane_readback();
    test_back_pressure();
    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
